/* sqrt_sum_top.f */
+incdir+.
wb_pkg.sv
sqrt_types_pkg.sv
isqrt_pipe.sv
align_fifo.sv
wb_regs.sv
sqrt_sum_ctrl.sv
sqrt_sum_top.sv
tb_sqrt_sum_top.sv

/* Bender.yml */
package:
  name: sqrt_sum

export_include_dirs:
  - .

sources:
  - files:
      - wb_pkg.sv
      - sqrt_types_pkg.sv
      - isqrt_pipe.sv
      - align_fifo.sv
      - wb_regs.sv
      - sqrt_sum_ctrl.sv
      - sqrt_sum_top.sv
  - target: test
    files:
      - tb_sqrt_sum_top.sv

/* tb_sqrt_sum_top.sv */
`include "sqrt_sum_defs.svh"

module tb_sqrt_sum_top
  import wb_pkg::*;
;

  logic    clk;
  logic    rst;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  int          pass_count;
  int          fail_count;
  int          errs_before;
  int          model_credits;  // free result slots as the host sees them.
  logic        exp_refused;
  logic [31:0] rng_state;
  logic [31:0] exp_q [$];

  sqrt_sum_top u_sqrt_sum_top (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // floor square root, one result bit at a time from the top.
  function automatic int unsigned floor_sqrt(input int unsigned v, input int bits);
    int unsigned r;
    int unsigned t;
    r = 0;
    for (int i = bits - 1; i >= 0; i--)
    begin
      t = r | (32'd1 << i);
      if (t * t <= v)
        r = t;
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      pass_count++;
    else
    begin
      fail_count++;
      $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  // both tasks start and end 1 unit after a rising edge.
  task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
    int n;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    n = 0;
    do
    begin
      @(posedge clk);
      #1;
      n++;
    end
    while (!wb_rsp.ack && n < 20);
    if (!wb_rsp.ack)
    begin
      fail_count++;
      $display("no ack within 20 cycles for a write to address %0d", adr);
    end
    wb_req = '0;
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
    int n;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = 1'b0;
    wb_req.adr = adr;
    wb_req.dat = '0;
    n = 0;
    do
    begin
      @(posedge clk);
      #1;
      n++;
    end
    while (!wb_rsp.ack && n < 20);
    if (!wb_rsp.ack)
    begin
      fail_count++;
      $display("no ack within 20 cycles for a read of address %0d", adr);
    end
    dat = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic start_job(input logic [7:0] a, input logic [7:0] b, input logic [15:0] c);
    wb_write(`SQS_ADDR_A, {24'b0, a});
    wb_write(`SQS_ADDR_B, {24'b0, b});
    wb_write(`SQS_ADDR_C, {16'b0, c});
    wb_write(`SQS_ADDR_CTRL, 32'd1);
    if (model_credits > 0)
    begin
      exp_q.push_back(floor_sqrt(a, 4) + floor_sqrt(b, 4) + floor_sqrt(c, 8));
      model_credits--;
    end
    else
      exp_refused = 1'b1;  // no free slot left.
  endtask

  // polls the status until the fifo holds at least want results.
  task automatic wait_results(input int want);
    logic [31:0] st;
    int n;
    n = 0;
    do
    begin
      wb_read(`SQS_ADDR_CTRL, st);
      n++;
    end
    while (st[7:4] < want && n < 40);
    if (st[7:4] < want)
    begin
      fail_count++;
      $display("result fifo never reached %0d entries, it holds %0d", want, st[7:4]);
    end
  endtask

  task automatic read_result();
    logic [31:0] got;
    logic [31:0] exp;
    wait_results(1);
    wb_read(`SQS_ADDR_RESULT, got);
    if (exp_q.size() == 0)
    begin
      fail_count++;
      $display("result read with no job expected by the model");
    end
    else
    begin
      exp = exp_q.pop_front();
      model_credits++;
      check_value("result", got, exp);
    end
  endtask

  task automatic report_test(input int num, input string what);
    $display("test %0d %s: %0d errors", num, what, fail_count - errs_before);
    errs_before = fail_count;
  endtask

  initial
  begin
    logic [31:0] rd;
    logic [31:0] r;
    pass_count = 0;
    fail_count = 0;
    errs_before = 0;
    model_credits = `SQS_RESULT_DEPTH;
    exp_refused = 1'b0;
    rng_state = 32'h7550_8613;
    rst = 1'b1;
    wb_req = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    wb_read(`SQS_ADDR_CTRL, rd);
    check_value("status", rd, 32'd0);
    wb_read(`SQS_ADDR_RESULT, rd);
    check_value("result", rd, 32'd0);  // empty fifo reads as zero.
    report_test(1, "reset state");

    for (int i = 0; i < 30; i++)
    begin
      rng_state = xorshift(rng_state);
      r = rng_state;
      start_job(r[7:0], r[15:8], r[31:16]);
      read_result();
    end
    report_test(2, "single jobs");

    start_job(8'd0, 8'd0, 16'd0);
    read_result();
    start_job(8'hff, 8'hff, 16'hffff);
    read_result();
    start_job(8'd144, 8'd144, 16'd65025);
    read_result();
    start_job(8'd0, 8'd144, 16'd144);
    read_result();
    report_test(3, "corner operands");

    // all starts go out before the first result is read.
    for (int i = 0; i < 6; i++)
    begin
      rng_state = xorshift(rng_state);
      r = rng_state;
      start_job(r[7:0], r[15:8], r[31:16]);
    end
    for (int i = 0; i < 6; i++)
      read_result();
    report_test(4, "jobs in flight");

    for (int i = 0; i < 10; i++)
    begin
      rng_state = xorshift(rng_state);
      r = rng_state;
      start_job(r[7:0], r[15:8], r[31:16]);
    end
    wait_results(`SQS_RESULT_DEPTH);
    wb_read(`SQS_ADDR_CTRL, rd);
    check_value("status.count", {28'b0, rd[7:4]}, `SQS_RESULT_DEPTH);
    check_value("status.job_refused", {31'b0, rd[0]}, {31'b0, exp_refused});
    for (int i = 0; i < `SQS_RESULT_DEPTH; i++)
      read_result();
    wb_write(`SQS_ADDR_CTRL, 32'd2);
    exp_refused = 1'b0;
    wb_read(`SQS_ADDR_CTRL, rd);
    check_value("status", rd, 32'd0);
    report_test(5, "admission limit");

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && exp_q.size() == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* sqrt_sum_top.sv */
`include "sqrt_sum_defs.svh"

module sqrt_sum_top
  import wb_pkg::*, sqrt_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  opnd_ab_t opnd_a;
  opnd_ab_t opnd_b;
  opnd_c_t  opnd_c;
  logic     start_req;
  logic     start_taken;
  logic     pipe_valid;
  opnd_ab_t pipe_a;
  opnd_ab_t pipe_b;
  opnd_c_t  pipe_c;
  logic     a_valid;
  logic     b_valid;
  logic     c_valid;
  root_ab_t a_root;
  root_ab_t b_root;
  root_c_t  c_root;
  root_ab_t a_head;
  root_ab_t b_head;
  logic     a_empty;
  logic     b_empty;
  logic     align_pop;
  logic     sum_push;
  sum_t     sum;
  sum_t     res_data;
  logic     res_empty;
  logic     res_pop;
  logic [$clog2(`SQS_RESULT_DEPTH):0] res_count;

  wb_regs u_wb_regs (
    .clk         (clk),
    .rst         (rst),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .opnd_a      (opnd_a),
    .opnd_b      (opnd_b),
    .opnd_c      (opnd_c),
    .start_req   (start_req),
    .start_taken (start_taken),
    .res_data    (res_data),
    .res_empty   (res_empty),
    .res_count   (res_count),
    .res_pop     (res_pop)
  );

  sqrt_sum_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .opnd_a      (opnd_a),
    .opnd_b      (opnd_b),
    .opnd_c      (opnd_c),
    .start_req   (start_req),
    .start_taken (start_taken),
    .pipe_valid  (pipe_valid),
    .pipe_a      (pipe_a),
    .pipe_b      (pipe_b),
    .pipe_c      (pipe_c),
    .c_valid     (c_valid),
    .c_root      (c_root),
    .a_head      (a_head),
    .b_head      (b_head),
    .a_empty     (a_empty),
    .b_empty     (b_empty),
    .align_pop   (align_pop),
    .sum_push    (sum_push),
    .sum         (sum),
    .res_pop     (res_pop)
  );

  isqrt_pipe #(.WIDTH(`SQS_WIDTH_AB)) u_sqrt_a (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (pipe_valid),
    .x         (pipe_a),
    .out_valid (a_valid),
    .root      (a_root)
  );

  isqrt_pipe #(.WIDTH(`SQS_WIDTH_AB)) u_sqrt_b (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (pipe_valid),
    .x         (pipe_b),
    .out_valid (b_valid),
    .root      (b_root)
  );

  isqrt_pipe #(.WIDTH(`SQS_WIDTH_C)) u_sqrt_c (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (pipe_valid),
    .x         (pipe_c),
    .out_valid (c_valid),
    .root      (c_root)
  );

  // a and b roots wait here for the slower c root.
  align_fifo #(.WIDTH($bits(root_ab_t)), .DEPTH(`SQS_ALIGN_DEPTH)) u_fifo_a (
    .clk   (clk),
    .rst   (rst),
    .push  (a_valid),
    .wdata (a_root),
    .pop   (align_pop),
    .rdata (a_head),
    .empty (a_empty),
    .count ()
  );

  align_fifo #(.WIDTH($bits(root_ab_t)), .DEPTH(`SQS_ALIGN_DEPTH)) u_fifo_b (
    .clk   (clk),
    .rst   (rst),
    .push  (b_valid),
    .wdata (b_root),
    .pop   (align_pop),
    .rdata (b_head),
    .empty (b_empty),
    .count ()
  );

  align_fifo #(.WIDTH($bits(sum_t)), .DEPTH(`SQS_RESULT_DEPTH)) u_fifo_res (
    .clk   (clk),
    .rst   (rst),
    .push  (sum_push),
    .wdata (sum),
    .pop   (res_pop),
    .rdata (res_data),
    .empty (res_empty),
    .count (res_count)
  );

endmodule

/* sqrt_sum_ctrl.sv */
`include "sqrt_sum_defs.svh"

module sqrt_sum_ctrl
  import sqrt_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  opnd_ab_t opnd_a,
  input  opnd_ab_t opnd_b,
  input  opnd_c_t  opnd_c,
  input  logic     start_req,
  output logic     start_taken,
  output logic     pipe_valid,
  output opnd_ab_t pipe_a,
  output opnd_ab_t pipe_b,
  output opnd_c_t  pipe_c,
  input  logic     c_valid,
  input  root_c_t  c_root,
  input  root_ab_t a_head,
  input  root_ab_t b_head,
  input  logic     a_empty,
  input  logic     b_empty,
  output logic     align_pop,
  output logic     sum_push,
  output sum_t     sum,
  input  logic     res_pop
);

  credit_t     credits;
  credit_t     credits_nx;
  credit_t     in_flight;
  credit_t     in_flight_nx;
  ctrl_state_t state;
  ctrl_state_t state_nx;

  // admit only with a reserved result slot.
  assign start_taken = start_req && (credits != '0);

  assign pipe_valid = start_taken;
  assign pipe_a = start_taken ? opnd_a : '0;  // quiet pipes between jobs.
  assign pipe_b = start_taken ? opnd_b : '0;
  assign pipe_c = start_taken ? opnd_c : '0;

  // a and b heads are already waiting when c lands.
  assign align_pop = c_valid;

  always_comb
  begin
    credits_nx = credits - credit_t'(start_taken) + credit_t'(res_pop);
    in_flight_nx = in_flight + credit_t'(start_taken) - credit_t'(sum_push);
    if (in_flight_nx == '0)
      state_nx = idle;
    else if (credits_nx == '0)
      state_nx = drain;
    else
      state_nx = run;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      credits <= credit_t'(`SQS_RESULT_DEPTH);
      in_flight <= '0;
      state <= idle;
      sum_push <= 1'b0;
    end
    else
    begin
      credits <= credits_nx;
      in_flight <= in_flight_nx;
      state <= state_nx;
      sum_push <= c_valid;  // sum lands one cycle after c.
    end
  end

  always_ff @(posedge clk)
  begin
    if (c_valid)
      sum <= sum_t'(a_head) + sum_t'(b_head) + sum_t'(c_root);
  end

  a_credit_range: assert property (@(posedge clk) disable iff (rst)
    credits <= credit_t'(`SQS_RESULT_DEPTH));

  a_align_ready: assert property (@(posedge clk) disable iff (rst)
    c_valid |-> !a_empty && !b_empty);

  // a root with no admitted job behind it.
  a_no_orphan: assert property (@(posedge clk) disable iff (rst)
    c_valid |-> state != idle);

endmodule

/* wb_regs.sv */
`include "sqrt_sum_defs.svh"

module wb_regs
  import wb_pkg::*, sqrt_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  output opnd_ab_t   opnd_a,
  output opnd_ab_t   opnd_b,
  output opnd_c_t    opnd_c,
  output logic       start_req,
  input  logic       start_taken,
  input  sum_t       res_data,
  input  logic       res_empty,
  input  logic [3:0] res_count,
  output logic       res_pop
);

  logic     ack_q;
  wb_data_t rdata_q;
  logic     job_refused;
  logic     req_acc;
  logic     wr_acc;
  logic     rd_acc;
  logic     ctrl_wr;
  wb_data_t status;

  // one access per request, ack in the following cycle.
  assign req_acc = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr_acc = req_acc && wb_req.we;
  assign rd_acc = req_acc && !wb_req.we;
  assign ctrl_wr = wr_acc && (wb_req.adr == `SQS_ADDR_CTRL);
  assign res_pop = rd_acc && (wb_req.adr == `SQS_ADDR_RESULT) && !res_empty;

  assign status = {24'b0, res_count, 3'b0, job_refused};

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdata_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ack_q <= 1'b0;
      start_req <= 1'b0;
    end
    else
    begin
      ack_q <= req_acc;
      start_req <= ctrl_wr && wb_req.dat[0];  // lines up with ack.
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      opnd_a <= '0;
      opnd_b <= '0;
      opnd_c <= '0;
    end
    else if (wr_acc)
    begin
      case (wb_req.adr)
        `SQS_ADDR_A: opnd_a <= wb_req.dat[`SQS_WIDTH_AB-1:0];
        `SQS_ADDR_B: opnd_b <= wb_req.dat[`SQS_WIDTH_AB-1:0];
        `SQS_ADDR_C: opnd_c <= wb_req.dat[`SQS_WIDTH_C-1:0];
        default:     ;
      endcase
    end
  end

  // sticky until the host clears it.
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      job_refused <= 1'b0;
    else if (ctrl_wr && wb_req.dat[1])
      job_refused <= 1'b0;
    else if (start_req && !start_taken)
      job_refused <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rd_acc)
    begin
      case (wb_req.adr)
        `SQS_ADDR_A:      rdata_q <= wb_data_t'(opnd_a);
        `SQS_ADDR_B:      rdata_q <= wb_data_t'(opnd_b);
        `SQS_ADDR_C:      rdata_q <= wb_data_t'(opnd_c);
        `SQS_ADDR_CTRL:   rdata_q <= status;
        `SQS_ADDR_RESULT: rdata_q <= res_empty ? '0 : wb_data_t'(res_data);
        default:          rdata_q <= '0;
      endcase
    end
  end

  a_ack_single: assert property (@(posedge clk) disable iff (rst)
    ack_q |=> !ack_q);

endmodule

/* align_fifo.sv */
module align_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    push,
  input  logic [WIDTH-1:0]        wdata,
  input  logic                    pop,
  output logic [WIDTH-1:0]        rdata,
  output logic                    empty,
  output logic [$clog2(DEPTH):0]  count
);

  localparam int PW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PW-1:0]    wr_ptr;
  logic [PW-1:0]    rd_ptr;
  logic             full;

  assign full = (count == DEPTH);
  assign empty = (count == '0);
  assign rdata = mem[rd_ptr];  // head always visible.

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH.
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    !(push && full));

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    !(pop && empty));

endmodule

/* isqrt_pipe.sv */
module isqrt_pipe #(
  parameter int WIDTH = 16
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  logic [WIDTH-1:0]   x,
  output logic               out_valid,
  output logic [WIDTH/2-1:0] root
);

  localparam int HALF = WIDTH / 2;
  localparam int RW = HALF + 2;  // remainder plus two new bits.

  logic             valid_q [HALF];
  logic [HALF-1:0]  root_q  [HALF];
  logic [RW-1:0]    rem_q   [HALF-1];  // last stage needs no remainder.
  logic [WIDTH-1:0] bits_q  [HALF-1];

  for (genvar s = 0; s < HALF; s++)
  begin : g_stage
    logic             v_in;
    logic [HALF-1:0]  q_in;
    logic [RW-1:0]    r_in;
    logic [WIDTH-1:0] b_in;
    logic [RW-1:0]    cand;
    logic [RW-1:0]    trial;
    logic             keep;

    if (s == 0)
    begin : g_first
      assign v_in = in_valid;
      assign q_in = '0;
      assign r_in = '0;
      assign b_in = x;
    end
    else
    begin : g_next
      assign v_in = valid_q[s-1];
      assign q_in = root_q[s-1];
      assign r_in = rem_q[s-1];
      assign b_in = bits_q[s-1];
    end

    // bring down the next bit pair and try 4q+1.
    assign cand = {r_in[RW-3:0], b_in[WIDTH-1 -: 2]};
    assign trial = {q_in, 2'b01};
    assign keep = (cand >= trial);

    always_ff @(posedge clk or posedge rst)
    begin
      if (rst)
        valid_q[s] <= 1'b0;
      else
        valid_q[s] <= v_in;
    end

    always_ff @(posedge clk)
    begin
      root_q[s] <= {q_in[HALF-2:0], keep};
    end

    if (s < HALF - 1)
    begin : g_carry
      always_ff @(posedge clk)
      begin
        rem_q[s] <= keep ? cand - trial : cand;
        bits_q[s] <= b_in << 2;  // next pair moves to the top.
      end
    end
  end

  assign out_valid = valid_q[HALF-1];
  assign root = root_q[HALF-1];

  a_latency_fwd: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> ##HALF out_valid);

  a_latency_bwd: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> $past(in_valid, HALF));

endmodule

/* sqrt_types_pkg.sv */
`include "sqrt_sum_defs.svh"

package sqrt_types_pkg;

  // operands.
  typedef logic [`SQS_WIDTH_AB-1:0] opnd_ab_t;
  typedef logic [`SQS_WIDTH_C-1:0] opnd_c_t;

  // a root is half as wide as its operand.
  typedef logic [`SQS_WIDTH_AB/2-1:0] root_ab_t;
  typedef logic [`SQS_WIDTH_C/2-1:0] root_c_t;

  typedef logic [`SQS_SUM_WIDTH-1:0] sum_t;

  // free result slots, 0 up to the full depth.
  typedef logic [$clog2(`SQS_RESULT_DEPTH):0] credit_t;

  typedef enum logic [1:0] {
    idle,  // nothing in flight.
    run,   // jobs in flight, room for more.
    drain  // jobs in flight, out of credits.
  } ctrl_state_t;

endpackage

/* wb_pkg.sv */
package wb_pkg;

  typedef logic [2:0] wb_adr_t;   // word address.
  typedef logic [31:0] wb_data_t;

  // master to slave.
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_adr_t  adr;
    wb_data_t dat;
  } wb_req_t;

  // slave to master.
  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

endpackage

/* sqrt_sum_defs.svh */
`ifndef SQRT_SUM_DEFS_SVH
`define SQRT_SUM_DEFS_SVH

// operand widths.
`define SQS_WIDTH_AB 8
`define SQS_WIDTH_C 16
`define SQS_SUM_WIDTH 16

// fifo depths, powers of two.
`define SQS_ALIGN_DEPTH 8
`define SQS_RESULT_DEPTH 8

// word addresses on the bus.
`define SQS_ADDR_A 3'd0
`define SQS_ADDR_B 3'd1
`define SQS_ADDR_C 3'd2
`define SQS_ADDR_CTRL 3'd3
`define SQS_ADDR_RESULT 3'd4

`endif
